/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= sgb_tb
FILELIST  ?= verilog.f
PASS_MSG  := sim passed
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

/* dv/sgb_checker.sv */
`timescale 1ns/1ps
`include "sgb_config.svh"

module sgb_checker (
	input logic                    clk_sys,
	input logic                    reset,
	input logic                    lcd_clkena,
	input logic                    sgb_lcd_clkena,
	input logic [`SGB_COLOR_W-1:0] sgb_lcd_data,
	input logic [1:0]              sgb_lcd_mode,
	input logic                    sgb_lcd_on,
	input logic                    sgb_lcd_vsync,
	input logic                    sgb_lcd_freeze,
	input logic                    sgb_pal_en,
	input logic [3:0]              joy_do
);

	int assert_fails = 0;

	// Freeze is one of the mask modes, so the palette path must be enabled
	freeze_needs_pal_en: assert property (@(posedge clk_sys) disable iff (reset)
		sgb_lcd_freeze |-> sgb_pal_en)
		else begin
			assert_fails++;
			$error("sgb_lcd_freeze high while sgb_pal_en is low");
		end

	clkena_delay: assert property (@(posedge clk_sys) disable iff (reset)
		sgb_lcd_clkena == $past(lcd_clkena, 2))
		else begin
			assert_fails++;
			$error("sgb_lcd_clkena is not lcd_clkena delayed by two cycles");
		end

	outputs_known: assert property (@(posedge clk_sys) disable iff (reset)
		!$isunknown({sgb_lcd_data, sgb_lcd_clkena, sgb_lcd_mode, sgb_lcd_on,
			sgb_lcd_vsync, sgb_lcd_freeze, sgb_pal_en, joy_do}))
		else begin
			assert_fails++;
			$error("unknown value on a top-level output");
		end

endmodule

/* dv/sgb_tb.sv */
`timescale 1ns/1ps
`include "sgb_config.svh"

module sgb_tb;

	localparam logic [1:0] M_OFF    = 2'd0;
	localparam logic [1:0] M_FREEZE = 2'd1;
	localparam logic [1:0] M_BLACK  = 2'd2;
	localparam logic [1:0] M_COLOR0 = 2'd3;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        sgb_en;
	logic [1:0]  joy_p54;
	logic [7:0]  joystick_0;
	logic [7:0]  joystick_1;
	logic [7:0]  joystick_2;
	logic [7:0]  joystick_3;
	logic        lcd_clkena;
	logic [14:0] lcd_data;
	logic [1:0]  lcd_data_gb;
	logic [1:0]  lcd_mode;
	logic        lcd_on;
	logic        lcd_vsync;
	logic [3:0]  joy_do;
	logic [14:0] sgb_lcd_data;
	logic        sgb_lcd_clkena;
	logic [1:0]  sgb_lcd_mode;
	logic        sgb_lcd_on;
	logic        sgb_lcd_vsync;
	logic        sgb_lcd_freeze;
	logic        sgb_pal_en;

	logic [31:0] lfsr = 32'h7e78217d;
	int          checks = 0;
	int          errors = 0;
	string       test_name = "idle";
	logic [7:0]  pkt [16];
	logic [7:0]  joy_m [4];
	logic [1:0]  mlt_m = 2'd0;

	// Reference model state
	logic [14:0] pal_m [4][4];
	logic        pal_written_m = 1'b0;
	logic        div_valid_m = 1'b0;
	logic        div_hv_m;
	logic [5:0]  div_pal_m;
	logic [4:0]  div_xy_m;
	logic [1:0]  mask_pend_m = M_OFF;
	logic [1:0]  mask_act_m = M_OFF;

	// Expected pixel travels alongside the DUT pipeline
	logic [14:0] exp_now;
	logic [14:0] exp_d1;
	logic [14:0] exp_d2;
	logic        vld_now = 1'b0;
	logic        vld_d1 = 1'b0;
	logic        vld_d2 = 1'b0;

	// Mode, on and vsync as sampled two edges ago
	logic [3:0]  ctl_d1;
	logic [3:0]  ctl_d2;

	sgb_top DUT (.*);

	bind sgb_top sgb_checker u_checker (.*);

	always #4 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		exp_d1 <= exp_now;
		vld_d1 <= vld_now;
		exp_d2 <= exp_d1;
		vld_d2 <= vld_d1;
		ctl_d1 <= {lcd_mode, lcd_on, lcd_vsync};
		ctl_d2 <= ctl_d1;
	end

	always @(negedge clk_sys) begin
		if (vld_d2)
			check_value(test_name, 32'(exp_d2), 32'(sgb_lcd_data));
		if (!reset)
			check_value("lcd_ctrl_delay", 32'(ctl_d2),
				32'({sgb_lcd_mode, sgb_lcd_on, sgb_lcd_vsync}));
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("Mismatch %s: expected %h, actual %h", name, exp, got);
		end
	endtask

	function automatic logic [3:0] exp_joy(input logic [1:0] id, input logic [1:0] lines);
		logic [7:0] pad;
		logic [3:0] dir;
		logic [3:0] btn;
		if (lines == 2'b11)
			return ~{2'b00, id};
		pad = mlt_m[0] ? joy_m[id] : (joy_m[0] | joy_m[1]);
		dir = ~{pad[2], pad[3], pad[1], pad[0]} | {4{lines[0]}};
		btn = ~pad[7:4] | {4{lines[1]}};
		return dir & btn;
	endfunction

	function automatic logic [14:0] exp_pixel(input int x, input int y,
			input logic [1:0] shade, input logic [14:0] raw);
		int         coord;
		logic [1:0] p;
		if (!pal_written_m && mask_act_m == M_OFF)
			return raw;
		if (mask_act_m == M_BLACK)
			return '0;
		if (shade == 2'd0 || mask_act_m == M_COLOR0)
			return pal_m[0][0];
		coord = div_hv_m ? y / 8 : x / 8;
		if (!div_valid_m)
			p = 2'd0;
		else if (coord > int'(div_xy_m))
			p = div_pal_m[1:0];
		else if (coord < int'(div_xy_m))
			p = div_pal_m[3:2];
		else
			p = div_pal_m[5:4];
		return pal_m[p][shade];
	endfunction

	task automatic drive_lines(input logic [1:0] v);
		@(posedge clk_sys);
		joy_p54 <= v;
	endtask

	task automatic set_joysticks();
		for (int i = 0; i < 4; i++)
			joy_m[i] = 8'(rand_bits(8));
		@(posedge clk_sys);
		joystick_0 <= joy_m[0];
		joystick_1 <= joy_m[1];
		joystick_2 <= joy_m[2];
		joystick_3 <= joy_m[3];
	endtask

	// Reset pulse, then 128 bits LSB first with both lines high in between
	task automatic send_packet(input int abort_bit);
		int n;
		n = 0;
		drive_lines(2'b00);
		drive_lines(2'b11);
		for (int b = 0; b < `SGB_PKT_BYTES; b++) begin
			for (int i = 0; i < 8; i++) begin
				if (n == abort_bit) begin
					drive_lines(2'b10);
					drive_lines(2'b01);
				end else begin
					drive_lines(pkt[b][i] ? 2'b01 : 2'b10);
				end
				drive_lines(2'b11);
				n++;
			end
		end
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic make_packet(input logic [4:0] code);
		pkt[0] = {code, 3'd1};
		for (int i = 1; i < `SGB_PKT_BYTES; i++)
			pkt[i] = 8'(rand_bits(8));
	endtask

	task automatic model_palettes(input logic [1:0] first, input logic [1:0] second);
		logic [14:0] col;
		for (int k = 0; k < 7; k++) begin
			col = {pkt[2 * k + 2][6:0], pkt[2 * k + 1]};
			if (k == 0)
				pal_m[0][0] = col;
			else if (k < 4)
				pal_m[first][k] = col;
			else
				pal_m[second][k - 3] = col;
		end
		pal_written_m = 1'b1;
	endtask

	task automatic send_mask(input logic [1:0] mode);
		make_packet(5'h17);
		pkt[1] = {6'd0, mode};
		send_packet(-1);
		mask_pend_m = mode;
	endtask

	task automatic run_frame(input int lines, input bit blank);
		logic [1:0]  shade;
		logic [14:0] raw;
		if (blank) begin
			@(posedge clk_sys);
			// Either condition blanks the screen
			if (rand_bits(1) != 0)
				lcd_on <= 1'b0;
			else
				lcd_mode <= 2'd1;
			repeat (4) @(posedge clk_sys);
			lcd_on   <= 1'b1;
			lcd_mode <= 2'd0;
			mask_act_m = mask_pend_m;
		end
		for (int y = 0; y < lines; y++) begin
			for (int x = 0; x < `SGB_LCD_W; x++) begin
				shade = 2'(rand_bits(2));
				raw   = 15'(rand_bits(15));
				@(posedge clk_sys);
				lcd_clkena  <= 1'b1;
				lcd_mode    <= 2'd3;
				lcd_data_gb <= shade;
				lcd_data    <= raw;
				lcd_vsync   <= (y == 0);
				exp_now     <= exp_pixel(x, y, shade, raw);
				vld_now     <= 1'b1;
			end
		end
		@(posedge clk_sys);
		lcd_clkena <= 1'b0;
		lcd_mode   <= 2'd0;
		vld_now    <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic wait_flag(input string what, input bit use_freeze);
		int t;
		t = 0;
		while ((use_freeze ? sgb_lcd_freeze : sgb_pal_en) !== 1'b1 && t < 1000) begin
			@(posedge clk_sys);
			t++;
		end
		if ((use_freeze ? sgb_lcd_freeze : sgb_pal_en) !== 1'b1) begin
			errors++;
			$display("Timeout waiting for %s to go high", what);
		end
	endtask

	initial begin
		logic [1:0] id_m;
		logic [1:0] sel;
		logic [1:0] p;
		reset       = 1'b1;
		sgb_en      = 1'b1;
		joy_p54     = 2'b11;
		joystick_0  = '0;
		joystick_1  = '0;
		joystick_2  = '0;
		joystick_3  = '0;
		lcd_clkena  = 1'b0;
		lcd_data    = '0;
		lcd_data_gb = '0;
		lcd_mode    = 2'd0;
		lcd_on      = 1'b1;
		lcd_vsync   = 1'b0;
		exp_now     = '0;
		for (int i = 0; i < 4; i++)
			for (int j = 0; j < 4; j++)
				pal_m[i][j] = '0;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (2) @(posedge clk_sys);

		test_name = "single_player";
		for (int n = 0; n < 20; n++) begin
			set_joysticks();
			for (int s = 0; s < 4; s++) begin
				sel = 2'(s);
				drive_lines(sel);
				@(negedge clk_sys);
				check_value(test_name, 32'(exp_joy(2'd0, sel)), 32'(joy_do));
			end
		end

		test_name = "multiplayer";
		make_packet(5'h11);
		pkt[1] = 8'h03;
		send_packet(-1);
		mlt_m = 2'd3;
		// Each one bit after byte 1 is a P15 rise that steps the id
		id_m = 2'd0;
		for (int b = 2; b < `SGB_PKT_BYTES; b++)
			for (int i = 0; i < 8; i++)
				id_m = id_m + 2'(pkt[b][i]);
		set_joysticks();
		drive_lines(2'b11);
		@(negedge clk_sys);
		check_value("multiplayer_id", 32'(exp_joy(id_m, 2'b11)), 32'(joy_do));
		for (int k = 0; k < 8; k++) begin
			drive_lines(2'b10);
			@(negedge clk_sys);
			check_value(test_name, 32'(exp_joy(id_m, 2'b10)), 32'(joy_do));
			drive_lines(2'b11);
			drive_lines(2'b01);
			@(negedge clk_sys);
			check_value(test_name, 32'(exp_joy(id_m, 2'b01)), 32'(joy_do));
			drive_lines(2'b11);
			@(posedge clk_sys);
			@(negedge clk_sys);
			id_m = id_m + 2'd1;
			check_value(test_name, 32'(exp_joy(id_m, 2'b11)), 32'(joy_do));
		end

		test_name = "palette";
		make_packet(5'h00);
		send_packet(-1);
		model_palettes(2'd0, 2'd1);
		make_packet(5'h03);
		send_packet(-1);
		model_palettes(2'd1, 2'd2);
		wait_flag("sgb_pal_en", 1'b0);
		run_frame(144, 1'b1);

		test_name = "divider";
		make_packet(5'h06);
		div_hv_m  = 1'(rand_bits(1));
		div_pal_m = 6'(rand_bits(6));
		div_xy_m  = 5'(rand_bits(5) % (div_hv_m ? `SGB_TILES_Y : `SGB_TILES_X));
		pkt[1] = {1'b0, div_hv_m, div_pal_m};
		pkt[2] = {3'd0, div_xy_m};
		send_packet(-1);
		div_valid_m = 1'b1;
		run_frame(144, 1'b1);

		test_name = "mask";
		p = 2'(rand_bits(2));
		make_packet(5'h06);
		pkt[1] = {2'b00, p, p, p};
		send_packet(-1);
		div_hv_m  = 1'b0;
		div_xy_m  = pkt[2][4:0];
		div_pal_m = {p, p, p};
		send_mask(M_BLACK);
		run_frame(4, 1'b0);
		run_frame(4, 1'b1);
		send_mask(M_COLOR0);
		run_frame(4, 1'b1);
		send_mask(M_FREEZE);
		run_frame(2, 1'b1);
		wait_flag("sgb_lcd_freeze", 1'b1);
		send_mask(M_OFF);
		run_frame(2, 1'b1);
		@(negedge clk_sys);
		check_value("mask_freeze_clear", 32'd0, 32'(sgb_lcd_freeze));

		test_name = "abort";
		make_packet(5'h01);
		send_packet(10);
		run_frame(8, 1'b1);
		make_packet(5'h02);
		send_packet(-1);
		model_palettes(2'd0, 2'd3);
		run_frame(8, 1'b1);

		errors += DUT.u_checker.assert_fails;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* src/sgb_cmd_decode.sv */
`timescale 1ns/1ps

module sgb_cmd_decode (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               byte_valid,
	input  logic [7:0]         byte_data,
	input  logic [3:0]         byte_idx,
	input  logic               first_packet,
	input  sgb_pkg::sgb_cmd_e  cmd,
	output logic               pal_wr,
	output logic [1:0]         pal_no,
	output logic [1:0]         col_no,
	output sgb_pkg::sgb_color_t pal_color,
	output logic               div_set,
	output logic               div_hv,
	output logic [5:0]         div_pal,
	output logic [4:0]         div_xy,
	output logic               mask_wr,
	output sgb_pkg::sgb_mask_e mask_mode,
	output logic [1:0]         mlt_ctrl
);
	import sgb_pkg::*;

	logic       hit;
	logic       is_pal_cmd;
	logic       pal_hi_byte;
	logic [7:0] color_lo;
	logic [2:0] col_idx;
	logic [1:0] pal_first;
	logic [1:0] pal_second;
	logic [1:0] tgt_pal;
	logic [1:0] tgt_col;

	assign hit         = byte_valid & first_packet;
	assign is_pal_cmd  = cmd inside {CMD_PAL01, CMD_PAL23, CMD_PAL03, CMD_PAL12};
	// Colours sit in bytes 1-2, 3-4 ... 13-14
	assign pal_hi_byte = ~byte_idx[0] && byte_idx >= 4'd2 && byte_idx <= 4'd14;
	assign col_idx     = byte_idx[3:1] - 3'd1;

	always_comb begin
		case (cmd)
			CMD_PAL01: {pal_first, pal_second} = {2'd0, 2'd1};
			CMD_PAL23: {pal_first, pal_second} = {2'd2, 2'd3};
			CMD_PAL03: {pal_first, pal_second} = {2'd0, 2'd3};
			CMD_PAL12: {pal_first, pal_second} = {2'd1, 2'd2};
			default:   {pal_first, pal_second} = {2'd0, 2'd0};
		endcase

		// Shared colour 0 always lands in palette 0
		if (col_idx == 3'd0)
			{tgt_pal, tgt_col} = {2'd0, 2'd0};
		else if (col_idx < 3'd4)
			{tgt_pal, tgt_col} = {pal_first, col_idx[1:0]};
		else
			{tgt_pal, tgt_col} = {pal_second, 2'(col_idx - 3'd3)};
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pal_wr   <= 1'b0;
			div_set  <= 1'b0;
			mask_wr  <= 1'b0;
			mlt_ctrl <= '0;
		end else begin
			pal_wr  <= hit & is_pal_cmd & pal_hi_byte;
			div_set <= hit && cmd == CMD_ATTR_DIV && byte_idx == 4'd2;
			mask_wr <= hit && cmd == CMD_MASK_EN && byte_idx == 4'd1;
			if (hit && cmd == CMD_MLT_REQ && byte_idx == 4'd1)
				mlt_ctrl <= byte_data[1:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (hit && is_pal_cmd) begin
			if (byte_idx[0]) begin
				color_lo <= byte_data;
			end else if (pal_hi_byte) begin
				pal_color <= {byte_data[6:0], color_lo};
				pal_no    <= tgt_pal;
				col_no    <= tgt_col;
			end
		end

		if (hit && cmd == CMD_ATTR_DIV) begin
			if (byte_idx == 4'd1)
				{div_hv, div_pal} <= byte_data[6:0];
			if (byte_idx == 4'd2)
				div_xy <= byte_data[4:0];
		end

		if (hit && cmd == CMD_MASK_EN && byte_idx == 4'd1)
			mask_mode <= sgb_mask_e'(byte_data[1:0]);
	end

endmodule

/* src/sgb_colorizer.sv */
`timescale 1ns/1ps
`include "sgb_config.svh"

module sgb_colorizer (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                sgb_en,
	input  logic                pal_wr,
	input  logic [1:0]          pal_no,
	input  logic [1:0]          col_no,
	input  sgb_pkg::sgb_color_t pal_color,
	input  logic                div_set,
	input  logic                div_hv,
	input  logic [5:0]          div_pal,
	input  logic [4:0]          div_xy,
	input  logic                mask_wr,
	input  sgb_pkg::sgb_mask_e  mask_mode,
	input  logic                lcd_clkena,
	input  sgb_pkg::sgb_color_t lcd_data,
	input  logic [1:0]          lcd_data_gb,
	input  logic [1:0]          lcd_mode,
	input  logic                lcd_on,
	input  logic                lcd_vsync,
	output sgb_pkg::sgb_color_t sgb_lcd_data,
	output logic                sgb_lcd_clkena,
	output logic [1:0]          sgb_lcd_mode,
	output logic                sgb_lcd_on,
	output logic                sgb_lcd_vsync,
	output logic                sgb_lcd_freeze,
	output logic                sgb_pal_en
);
	import sgb_pkg::*;

	localparam int TILE_X_W = $clog2(`SGB_TILES_X);
	localparam int TILE_Y_W = $clog2(`SGB_TILES_Y);
	localparam logic [7:0] LAST_PIX = 8'(`SGB_LCD_W - 1);

	sgb_color_t          palette [`SGB_NUM_PALS][4];
	logic                pal_written;
	logic                div_valid;
	logic                div_hv_r;
	logic [5:0]          div_pal_r;
	logic [4:0]          div_xy_r;
	sgb_mask_e           mask_pend;
	sgb_mask_e           mask_act;
	logic                lcd_off;
	logic                old_lcd_off;
	logic [7:0]          pix_x;
	logic [2:0]          fine_y;
	logic [TILE_X_W-1:0] tile_x;
	logic [TILE_Y_W-1:0] tile_y;
	logic [4:0]          div_coord;
	logic [1:0]          pix_pal;
	sgb_color_t          lcd_data_r;
	logic [1:0]          gb_r;
	logic [1:0]          pal_r;
	logic [1:0]          mode_r;
	logic                clkena_r;
	logic                on_r;
	logic                vsync_r;

	assign lcd_off = ~lcd_on | (lcd_mode == 2'd1);
	assign tile_x  = pix_x[TILE_X_W+2:3];

	// Divider palette from the live tile position
	always_comb begin
		div_coord = div_hv_r ? tile_y : tile_x;
		if (!div_valid)
			pix_pal = 2'd0;
		else if (div_coord > div_xy_r)
			pix_pal = div_pal_r[1:0];
		else if (div_coord < div_xy_r)
			pix_pal = div_pal_r[3:2];
		else
			pix_pal = div_pal_r[5:4];
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			for (int p = 0; p < `SGB_NUM_PALS; p++) begin
				for (int c = 0; c < 4; c++) begin
					palette[p][c] <= '0;
				end
			end
			pal_written <= 1'b0;
			div_valid   <= 1'b0;
			div_hv_r    <= 1'b0;
			div_pal_r   <= '0;
			div_xy_r    <= '0;
			mask_pend   <= MASK_OFF;
			mask_act    <= MASK_OFF;
		end else begin
			if (pal_wr) begin
				palette[pal_no][col_no] <= pal_color;
				pal_written             <= 1'b1;
			end
			if (div_set) begin
				div_valid <= 1'b1;
				div_hv_r  <= div_hv;
				div_pal_r <= div_pal;
				div_xy_r  <= div_xy;
			end
			if (mask_wr)
				mask_pend <= mask_mode;
			// New mask only switches in while the screen is blanked
			if (lcd_off)
				mask_act <= mask_pend;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_lcd_off <= 1'b0;
			pix_x       <= '0;
			fine_y      <= '0;
			tile_y      <= '0;
		end else begin
			old_lcd_off <= lcd_off;
			if (~old_lcd_off & lcd_off) begin
				pix_x  <= '0;
				fine_y <= '0;
				tile_y <= '0;
			end else if (lcd_clkena & ~lcd_off) begin
				if (pix_x == LAST_PIX) begin
					pix_x  <= '0;
					fine_y <= fine_y + 3'd1;
					if (&fine_y)
						tile_y <= tile_y + 1'b1;
				end else begin
					pix_x <= pix_x + 8'd1;
				end
			end
		end
	end

	// Two stage pixel pipeline
	always_ff @(posedge clk_sys) begin
		lcd_data_r <= lcd_data;
		gb_r       <= lcd_data_gb;
		pal_r      <= pix_pal;
		clkena_r   <= lcd_clkena;
		mode_r     <= lcd_mode;
		on_r       <= lcd_on;
		vsync_r    <= lcd_vsync;

		if (~sgb_en | (~pal_written & (mask_act == MASK_OFF)))
			sgb_lcd_data <= lcd_data_r;
		else if (mask_act == MASK_BLACK)
			sgb_lcd_data <= '0;
		else if (gb_r == 2'd0 || mask_act == MASK_COLOR0)
			sgb_lcd_data <= palette[0][0];
		else
			sgb_lcd_data <= palette[pal_r][gb_r];

		sgb_lcd_clkena <= clkena_r;
		sgb_lcd_mode   <= mode_r;
		sgb_lcd_on     <= on_r;
		sgb_lcd_vsync  <= vsync_r;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sgb_lcd_freeze <= 1'b0;
			sgb_pal_en     <= 1'b0;
		end else begin
			sgb_lcd_freeze <= sgb_en & (mask_act == MASK_FREEZE);
			sgb_pal_en     <= sgb_en & (pal_written | (mask_act != MASK_OFF));
		end
	end

endmodule

/* src/sgb_config.svh */
`ifndef SGB_CONFIG_SVH
`define SGB_CONFIG_SVH

// Bytes in one command packet, header included
`define SGB_PKT_BYTES 16

// Visible LCD pixels per line
`define SGB_LCD_W 160

// Screen size in 8x8 tiles
`define SGB_TILES_X 20
`define SGB_TILES_Y 18

// One RGB555 colour
`define SGB_COLOR_W 15

// Palettes of four colours each
`define SGB_NUM_PALS 4

`endif

/* src/sgb_joypad_mux.sv */
`timescale 1ns/1ps

module sgb_joypad_mux (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       sgb_en,
	input  logic [1:0] joy_p54,
	input  logic [7:0] joystick_0,
	input  logic [7:0] joystick_1,
	input  logic [7:0] joystick_2,
	input  logic [7:0] joystick_3,
	input  logic [1:0] mlt_ctrl,
	output logic [3:0] joy_do
);

	logic       p14;
	logic       p15;
	logic       old_p15;
	logic [1:0] joypad_id;
	logic [7:0] joystick;
	logic [3:0] joy_dir;
	logic [3:0] joy_btn;

	assign p14 = joy_p54[0];
	assign p15 = joy_p54[1];

	// Id wraps at 2 or 4 players through the mlt_ctrl mask
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_p15   <= 1'b1;
			joypad_id <= '0;
		end else begin
			old_p15 <= p15;
			if (sgb_en & ~old_p15 & p15)
				joypad_id <= (joypad_id + 2'd1) & mlt_ctrl;
		end
	end

	always_comb begin
		if (~sgb_en | ~mlt_ctrl[0]) begin
			joystick = joystick_0 | joystick_1;
		end else begin
			case (joypad_id)
				2'd0:    joystick = joystick_0;
				2'd1:    joystick = joystick_1;
				2'd2:    joystick = joystick_2;
				default: joystick = joystick_3;
			endcase
		end
	end

	// Active low key matrix rows
	assign joy_dir = ~{joystick[2], joystick[3], joystick[1], joystick[0]} | {4{p14}};
	assign joy_btn = ~{joystick[7], joystick[6], joystick[5], joystick[4]} | {4{p15}};

	assign joy_do = (sgb_en & p15 & p14) ? ~{2'b00, joypad_id} : (joy_dir & joy_btn);

endmodule

/* src/sgb_packet_rx.sv */
`timescale 1ns/1ps
`include "sgb_config.svh"

module sgb_packet_rx (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              sgb_en,
	input  logic [1:0]        joy_p54,
	output logic              byte_valid,
	output logic [7:0]        byte_data,
	output logic [3:0]        byte_idx,
	output logic              first_packet,
	output sgb_pkg::sgb_cmd_e cmd
);
	import sgb_pkg::*;

	localparam logic [3:0] LAST_BYTE = 4'(`SGB_PKT_BYTES - 1);

	logic          p14;
	logic          p15;
	logic          old_p14;
	logic          old_p15;
	logic [2:0]    bit_cnt;
	logic [2:0]    packet_cnt;
	logic [2:0]    len;
	logic          packet_end;
	logic          bit_take;
	logic          reset_pulse;
	logic          abort;
	sgb_pkt_byte_u shift;

	assign p14 = joy_p54[0];
	assign p15 = joy_p54[1];

	// Bit strobe is one line dropping out of the idle high state
	assign bit_take    = sgb_en & old_p15 & old_p14 & (p15 ^ p14) & ~packet_end;
	assign reset_pulse = sgb_en & ~p15 & ~p14;
	// One line low straight to the other line low
	assign abort       = sgb_en & (old_p15 ^ old_p14) & (p15 ^ p14) & (old_p15 ^ p15);

	assign byte_data    = shift.raw;
	assign first_packet = (packet_cnt == 3'd0);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_p14    <= 1'b1;
			old_p15    <= 1'b1;
			bit_cnt    <= '0;
			byte_idx   <= '0;
			packet_cnt <= '0;
			packet_end <= 1'b1;
			byte_valid <= 1'b0;
		end else begin
			old_p14    <= p14;
			old_p15    <= p15;
			byte_valid <= 1'b0;

			if (bit_take) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (&bit_cnt)
					byte_valid <= 1'b1;
			end

			if (byte_valid) begin
				byte_idx <= byte_idx + 4'd1;
				if (byte_idx == LAST_BYTE) begin
					if (packet_cnt + 3'd1 >= len) begin
						packet_cnt <= '0;
						packet_end <= 1'b1;
					end else begin
						packet_cnt <= packet_cnt + 3'd1;
					end
				end
			end

			if (abort) begin
				packet_end <= 1'b1;
				packet_cnt <= '0;
			end

			if (reset_pulse) begin
				bit_cnt    <= '0;
				byte_idx   <= '0;
				packet_end <= 1'b0;
			end
		end
	end

	// LSB first, P15 low means a one
	always_ff @(posedge clk_sys) begin
		if (bit_take)
			shift.raw <= {~p15, shift.raw[7:1]};
		if (byte_valid && first_packet && byte_idx == 4'd0) begin
			cmd <= shift.hdr.cmd;
			len <= shift.hdr.len;
		end
	end

endmodule

/* src/sgb_pkg.sv */
`include "sgb_config.svh"

package sgb_pkg;

	// Command codes handled by the decoder
	typedef enum logic [4:0] {
		CMD_PAL01    = 5'h00,
		CMD_PAL23    = 5'h01,
		CMD_PAL03    = 5'h02,
		CMD_PAL12    = 5'h03,
		CMD_ATTR_DIV = 5'h06,
		CMD_MLT_REQ  = 5'h11,
		CMD_MASK_EN  = 5'h17
	} sgb_cmd_e;

	typedef struct packed {
		sgb_cmd_e   cmd;
		logic [2:0] len;
	} sgb_pkt_hdr_t;

	// Byte 0 of a packet is a header, every other byte is plain data
	typedef union packed {
		sgb_pkt_hdr_t hdr;
		logic [7:0]   raw;
	} sgb_pkt_byte_u;

	typedef logic [`SGB_COLOR_W-1:0] sgb_color_t;

	typedef enum logic [1:0] {
		MASK_OFF    = 2'd0,
		MASK_FREEZE = 2'd1,
		MASK_BLACK  = 2'd2,
		MASK_COLOR0 = 2'd3
	} sgb_mask_e;

endpackage

/* src/sgb_top.sv */
`timescale 1ns/1ps

module sgb_top (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                sgb_en,
	input  logic [1:0]          joy_p54,
	input  logic [7:0]          joystick_0,
	input  logic [7:0]          joystick_1,
	input  logic [7:0]          joystick_2,
	input  logic [7:0]          joystick_3,
	input  logic                lcd_clkena,
	input  sgb_pkg::sgb_color_t lcd_data,
	input  logic [1:0]          lcd_data_gb,
	input  logic [1:0]          lcd_mode,
	input  logic                lcd_on,
	input  logic                lcd_vsync,
	output logic [3:0]          joy_do,
	output sgb_pkg::sgb_color_t sgb_lcd_data,
	output logic                sgb_lcd_clkena,
	output logic [1:0]          sgb_lcd_mode,
	output logic                sgb_lcd_on,
	output logic                sgb_lcd_vsync,
	output logic                sgb_lcd_freeze,
	output logic                sgb_pal_en
);
	import sgb_pkg::*;

	logic       byte_valid;
	logic [7:0] byte_data;
	logic [3:0] byte_idx;
	logic       first_packet;
	sgb_cmd_e   cmd;
	logic       pal_wr;
	logic [1:0] pal_no;
	logic [1:0] col_no;
	sgb_color_t pal_color;
	logic       div_set;
	logic       div_hv;
	logic [5:0] div_pal;
	logic [4:0] div_xy;
	logic       mask_wr;
	sgb_mask_e  mask_mode;
	logic [1:0] mlt_ctrl;

	sgb_packet_rx u_packet_rx (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.sgb_en       (sgb_en),
		.joy_p54      (joy_p54),
		.byte_valid   (byte_valid),
		.byte_data    (byte_data),
		.byte_idx     (byte_idx),
		.first_packet (first_packet),
		.cmd          (cmd)
	);

	sgb_cmd_decode u_cmd_decode (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.byte_valid   (byte_valid),
		.byte_data    (byte_data),
		.byte_idx     (byte_idx),
		.first_packet (first_packet),
		.cmd          (cmd),
		.pal_wr       (pal_wr),
		.pal_no       (pal_no),
		.col_no       (col_no),
		.pal_color    (pal_color),
		.div_set      (div_set),
		.div_hv       (div_hv),
		.div_pal      (div_pal),
		.div_xy       (div_xy),
		.mask_wr      (mask_wr),
		.mask_mode    (mask_mode),
		.mlt_ctrl     (mlt_ctrl)
	);

	sgb_joypad_mux u_joypad_mux (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.sgb_en     (sgb_en),
		.joy_p54    (joy_p54),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.joystick_2 (joystick_2),
		.joystick_3 (joystick_3),
		.mlt_ctrl   (mlt_ctrl),
		.joy_do     (joy_do)
	);

	sgb_colorizer u_colorizer (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.sgb_en         (sgb_en),
		.pal_wr         (pal_wr),
		.pal_no         (pal_no),
		.col_no         (col_no),
		.pal_color      (pal_color),
		.div_set        (div_set),
		.div_hv         (div_hv),
		.div_pal        (div_pal),
		.div_xy         (div_xy),
		.mask_wr        (mask_wr),
		.mask_mode      (mask_mode),
		.lcd_clkena     (lcd_clkena),
		.lcd_data       (lcd_data),
		.lcd_data_gb    (lcd_data_gb),
		.lcd_mode       (lcd_mode),
		.lcd_on         (lcd_on),
		.lcd_vsync      (lcd_vsync),
		.sgb_lcd_data   (sgb_lcd_data),
		.sgb_lcd_clkena (sgb_lcd_clkena),
		.sgb_lcd_mode   (sgb_lcd_mode),
		.sgb_lcd_on     (sgb_lcd_on),
		.sgb_lcd_vsync  (sgb_lcd_vsync),
		.sgb_lcd_freeze (sgb_lcd_freeze),
		.sgb_pal_en     (sgb_pal_en)
	);

endmodule

/* verilog.f */
+incdir+src
src/sgb_pkg.sv
src/sgb_packet_rx.sv
src/sgb_cmd_decode.sv
src/sgb_joypad_mux.sv
src/sgb_colorizer.sv
src/sgb_top.sv
dv/sgb_checker.sv
dv/sgb_tb.sv
